// File: filelist.f
source/quad_pkg.sv
source/prefetch_buffer.sv
source/weight_table.sv
source/compute_engine_array.sv
source/quad_job_ctrl.sv
source/quad_top.sv
test/quad_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal --top-module quad_tb \
    -f filelist.f -o quad_sim || exit 1
./obj_dir/quad_sim | tee /dev/stderr | grep -q "Test OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: source/compute_engine_array.sv
module compute_engine_array
    import quad_pkg::*;
(
    input  logic         clk_core,
    input  logic         rst,
    input  logic         relu_en,
    input  pixel_beat_t  pixel_in,
    input  weight_beat_t weight_in,
    input  logic         mac_start,
    input  logic         mac_last,
    input  logic         result_accept,
    output logic         mac_ready,
    output logic         result_valid,
    output result_beat_t result_data
);

    acc_t acc      [num_ce];
    acc_t sum_next [num_ce];

    logic in_win;
    logic col_valid;
    logic col_valid_d;
    logic start_d;
    logic last_d;

    ////////////////////////////////////////////////////////////////////////////
    // Column tracking
    ////////////////////////////////////////////////////////////////////////////

    // Inside a window the controller issues exactly when mac_ready is high
    assign col_valid = mac_start || (in_win && mac_ready);

    // Stall on a held result or a last column still on its way in
    assign mac_ready = !(result_valid && !result_accept) && !last_d;

    always_ff @(posedge clk_core) begin
        if (rst) begin
            in_win       <= 1'b0;
            col_valid_d  <= 1'b0;
            start_d      <= 1'b0;
            last_d       <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            // Tags are delayed to line up with the registered pixel and weight
            col_valid_d <= col_valid;
            start_d     <= mac_start;
            last_d      <= mac_last;
            if (mac_last) begin
                in_win <= 1'b0;
            end else if (mac_start) begin
                in_win <= 1'b1;
            end
            if (col_valid_d && last_d) begin
                result_valid <= 1'b1;
            end else if (result_accept) begin
                result_valid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per-lane ReLU and multiply-accumulate
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        pixel_t                                pix;
        weight_t                               wgt;
        logic signed [pixel_width+weight_width-1:0] prod;
        for (int i = 0; i < num_ce; i++) begin
            pix = pixel_in[i*pixel_width +: pixel_width];
            wgt = weight_in[i*weight_width +: weight_width];
            if (relu_en && pix[pixel_width-1]) begin
                pix = '0;
            end
            prod        = pix * wgt;
            sum_next[i] = (start_d ? acc_t'(0) : acc[i]) + acc_t'(prod);
        end
    end

    always_ff @(posedge clk_core) begin
        for (int i = 0; i < num_ce; i++) begin
            if (col_valid_d) begin
                acc[i] <= sum_next[i];
            end
            if (col_valid_d && last_d) begin
                result_data[i*acc_width +: acc_width] <= sum_next[i];
            end
        end
    end

endmodule

// File: source/prefetch_buffer.sv
module prefetch_buffer
    import quad_pkg::*;
(
    input  logic        clk_core,
    input  logic        rst,
    input  logic        loading,
    input  logic        pixel_valid,
    input  pixel_beat_t pixel_data,
    input  logic        rd_en,
    output logic        pixel_ready,
    output pixel_beat_t pixel_out
);

    pixel_beat_t                    mem [pfb_depth];
    logic [$clog2(pfb_depth)-1:0]   wr_ptr;
    logic [$clog2(pfb_depth)-1:0]   rd_ptr;

    // Pixels only flow while the controller holds a fetch open
    assign pixel_ready = pixel_valid && loading;

    // Pointers wrap on their own since one row never exceeds the depth
    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (pixel_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_core) begin
        if (pixel_ready) begin
            mem[wr_ptr] <= pixel_data;
        end
    end

    // Registered read that lines up with the weight table output
    always_ff @(posedge clk_core) begin
        if (rd_en) begin
            pixel_out <= mem[rd_ptr];
        end
    end

endmodule

// File: source/quad_job_ctrl.sv
module quad_job_ctrl
    import quad_pkg::*;
(
    input  logic        clk_core,
    input  logic        rst,
    input  logic        job_start,
    input  job_params_t job_parameters,
    input  logic        job_fetch_ack,
    input  logic        job_fetch_complete,
    input  logic        job_complete_ack,
    input  logic        mac_ready,
    output logic        job_accept,
    output logic        job_fetch_request,
    output logic        job_complete,
    output logic        loading,
    output logic        weights_open,
    output logic        relu_en,
    output logic        rd_en,
    output wht_addr_t   wht_addr,
    output logic        mac_start,
    output logic        mac_last
);

    quad_state_t               state;
    job_params_t               params;
    row_count_t                row_cnt;
    col_count_t                col_cnt;
    wht_addr_t                 win_pos;
    logic [accept_stretch-1:0] accept_sr;

    logic take_job;
    logic issue;
    logic col_last;
    logic row_last;
    logic win_last;

    ////////////////////////////////////////////////////////////////////////////
    // Issue control
    ////////////////////////////////////////////////////////////////////////////

    assign take_job = (state == st_idle) && job_start;
    // One column per cycle unless the engines push back
    assign issue    = (state == st_ce_active) && mac_ready;

    assign col_last = (8'(col_cnt) == params.num_cols - 8'd1);
    assign row_last = (8'(row_cnt) == params.num_rows - 8'd1);
    assign win_last = (8'(win_pos) == params.kernel_len - 8'd1);

    assign rd_en     = issue;
    assign wht_addr  = win_pos;
    assign mac_start = issue && (win_pos == '0);
    // End of row also closes a short trailing window
    assign mac_last  = issue && (win_last || col_last);

    ////////////////////////////////////////////////////////////////////////////
    // Handshake outputs
    ////////////////////////////////////////////////////////////////////////////

    // High for accept_stretch cycles, starting one cycle after the start
    assign job_accept        = |accept_sr;
    assign job_fetch_request = (state == st_prime_buffer);
    // Held off until the final window sum has left the engines
    assign job_complete      = (state == st_job_done) && mac_ready;
    assign loading           = (state == st_wait_pfb_load);
    assign weights_open      = (state == st_idle);
    assign relu_en           = params.relu_en;

    always_ff @(posedge clk_core) begin
        if (rst) begin
            accept_sr <= '0;
        end else begin
            accept_sr <= {accept_sr[accept_stretch-2:0], take_job};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Job FSM with row, column and window counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state   <= st_idle;
            params  <= '0;
            row_cnt <= '0;
            col_cnt <= '0;
            win_pos <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (job_start) begin
                        params  <= job_parameters;
                        row_cnt <= '0;
                        state   <= st_prime_buffer;
                    end
                end
                st_prime_buffer: begin
                    if (job_fetch_ack) begin
                        state <= st_wait_pfb_load;
                    end
                end
                st_wait_pfb_load: begin
                    // Row is complete in the buffer
                    if (job_fetch_complete) begin
                        col_cnt <= '0;
                        win_pos <= '0;
                        state   <= st_ce_active;
                    end
                end
                st_ce_active: begin
                    if (issue) begin
                        if (col_last) begin
                            if (row_last) begin
                                state <= st_job_done;
                            end else begin
                                row_cnt <= row_cnt + 1'b1;
                                state   <= st_prime_buffer;
                            end
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                            win_pos <= win_last ? '0 : win_pos + 1'b1;
                        end
                    end
                end
                st_job_done: begin
                    if (job_complete && job_complete_ack) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: source/quad_pkg.sv
package quad_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Array geometry and storage sizes
    ////////////////////////////////////////////////////////////////////////////

    // Two array engines of two compute engines each
    localparam int num_ce         = 4;
    localparam int pixel_width    = 16;
    localparam int weight_width   = 16;
    localparam int acc_width      = 40;
    // Weights per engine and so the upper bound on kernel_len
    localparam int wht_depth      = 16;
    // Beats per row and so the upper bound on num_cols
    localparam int pfb_depth      = 32;
    localparam int accept_stretch = 5;

    ////////////////////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [pixel_width-1:0]  pixel_t;
    typedef logic signed [weight_width-1:0] weight_t;
    typedef logic signed [acc_width-1:0]    acc_t;

    // Lane 0 sits in the low bits of every beat
    typedef logic [num_ce*pixel_width-1:0]  pixel_beat_t;
    typedef logic [num_ce*weight_width-1:0] weight_beat_t;
    typedef logic [num_ce*acc_width-1:0]    result_beat_t;

    typedef logic [$clog2(wht_depth)-1:0]   wht_addr_t;
    typedef logic [5:0]                     col_count_t;
    typedef logic [5:0]                     row_count_t;

    typedef struct packed {
        logic [7:0] num_rows;
        logic [7:0] num_cols;
        logic [7:0] kernel_len;
        logic       relu_en;
        logic [6:0] reserved;
    } job_params_t;

    typedef enum logic [2:0] {
        st_idle,
        st_prime_buffer,
        st_wait_pfb_load,
        st_ce_active,
        st_job_done
    } quad_state_t;

endpackage

// File: source/quad_top.sv
module quad_top
    import quad_pkg::*;
(
    input  logic         clk_core,
    input  logic         rst,

    // Job handshake with the host
    input  logic         job_start,
    output logic         job_accept,
    input  job_params_t  job_parameters,
    output logic         job_fetch_request,
    input  logic         job_fetch_ack,
    input  logic         job_fetch_complete,
    output logic         job_complete,
    input  logic         job_complete_ack,

    // Weight stream
    input  logic         weight_valid,
    output logic         weight_ready,
    input  weight_beat_t weight_data,

    // Pixel stream
    input  logic         pixel_valid,
    output logic         pixel_ready,
    input  pixel_beat_t  pixel_data,

    // Window sums
    output logic         result_valid,
    input  logic         result_accept,
    output result_beat_t result_data
);

    logic         loading;
    logic         weights_open;
    logic         relu_en;
    logic         rd_en;
    wht_addr_t    wht_addr;
    logic         mac_start;
    logic         mac_last;
    logic         mac_ready;
    pixel_beat_t  pfb_pixels;
    weight_beat_t wht_weights;

    quad_job_ctrl u_job_ctrl (
        .clk_core           (clk_core),
        .rst                (rst),
        .job_start          (job_start),
        .job_parameters     (job_parameters),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete_ack   (job_complete_ack),
        .mac_ready          (mac_ready),
        .job_accept         (job_accept),
        .job_fetch_request  (job_fetch_request),
        .job_complete       (job_complete),
        .loading            (loading),
        .weights_open       (weights_open),
        .relu_en            (relu_en),
        .rd_en              (rd_en),
        .wht_addr           (wht_addr),
        .mac_start          (mac_start),
        .mac_last           (mac_last)
    );

    prefetch_buffer u_prefetch_buffer (
        .clk_core    (clk_core),
        .rst         (rst),
        .loading     (loading),
        .pixel_valid (pixel_valid),
        .pixel_data  (pixel_data),
        .rd_en       (rd_en),
        .pixel_ready (pixel_ready),
        .pixel_out   (pfb_pixels)
    );

    weight_table u_weight_table (
        .clk_core     (clk_core),
        .rst          (rst),
        .weights_open (weights_open),
        .weight_valid (weight_valid),
        .weight_data  (weight_data),
        .rd_en        (rd_en),
        .wht_addr     (wht_addr),
        .weight_ready (weight_ready),
        .weight_out   (wht_weights)
    );

    compute_engine_array u_engines (
        .clk_core      (clk_core),
        .rst           (rst),
        .relu_en       (relu_en),
        .pixel_in      (pfb_pixels),
        .weight_in     (wht_weights),
        .mac_start     (mac_start),
        .mac_last      (mac_last),
        .result_accept (result_accept),
        .mac_ready     (mac_ready),
        .result_valid  (result_valid),
        .result_data   (result_data)
    );

endmodule

// File: source/weight_table.sv
module weight_table
    import quad_pkg::*;
(
    input  logic         clk_core,
    input  logic         rst,
    input  logic         weights_open,
    input  logic         weight_valid,
    input  weight_beat_t weight_data,
    input  logic         rd_en,
    input  wht_addr_t    wht_addr,
    output logic         weight_ready,
    output weight_beat_t weight_out
);

    weight_beat_t mem [wht_depth];
    wht_addr_t    wr_addr;

    // Loading is only allowed between jobs
    assign weight_ready = weight_valid && weights_open;

    // Next load starts over at address 0 once a job takes the table
    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_addr <= '0;
        end else if (!weights_open) begin
            wr_addr <= '0;
        end else if (weight_ready) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk_core) begin
        if (weight_ready) begin
            mem[wr_addr] <= weight_data;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rd_en) begin
            weight_out <= mem[wht_addr];
        end
    end

endmodule

// File: test/quad_tb.sv
module quad_tb
    import quad_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int tdata_depth = 64;
    localparam int wait_limit  = 400;
    localparam int file_jobs   = 2;

    logic         clk_core = 1'b0;
    logic         rst;
    logic         job_start;
    logic         job_accept;
    job_params_t  job_parameters;
    logic         job_fetch_request;
    logic         job_fetch_ack;
    logic         job_fetch_complete;
    logic         job_complete;
    logic         job_complete_ack;
    logic         weight_valid;
    logic         weight_ready;
    weight_beat_t weight_data;
    logic         pixel_valid;
    logic         pixel_ready;
    pixel_beat_t  pixel_data;
    logic         result_valid;
    logic         result_accept = 1'b0;
    result_beat_t result_data;

    // Widest word of the data file is a result beat
    result_beat_t tdata [tdata_depth];
    result_beat_t exp_q [$];
    integer       seed         = 79;
    logic         stall_en     = 1'b0;
    logic         fetch_seen   = 1'b0;
    int           fetch_count  = 0;
    int           result_count = 0;
    string        test_name    = "reset";

    quad_top u_quad_top (.*);

    always #4 clk_core = ~clk_core;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_result(input string what, input result_beat_t exp,
                                input result_beat_t act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s %s: expected %h, actual %h",
                               test_name, what, exp, act));
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s %s: expected %b, actual %b",
                               test_name, what, exp, act));
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            fail_run($sformatf("Mismatch %s %s: expected %0d, actual %0d",
                               test_name, what, exp, act));
        end
    endtask

    task automatic tick();
        @(posedge clk_core);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////////////////////////////////////////

    // Random back-pressure only in the second pass
    always @(posedge clk_core) begin
        result_accept <= stall_en ? (($random(seed) & 1) != 0) : 1'b1;
    end

    always @(posedge clk_core) begin
        if (!rst && result_valid && result_accept) begin
            if (exp_q.size() == 0) begin
                fail_run("Result beat arrived when none was expected");
            end else begin
                check_result("result_data", exp_q.pop_front(), result_data);
                result_count++;
            end
        end
    end

    // Count rising edges of the fetch request
    always @(posedge clk_core) begin
        if (!rst && job_fetch_request && !fetch_seen) begin
            fetch_count++;
        end
        fetch_seen <= job_fetch_request;
    end

    ////////////////////////////////////////////////////////////////////////////
    // One job from the data file
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_job(input int base, output int next);
        job_params_t p;
        int          rows;
        int          cols;
        int          n_exp;
        int          pix_base;
        int          fetch_start;
        int          result_start;
        int          n;
        p            = job_params_t'(tdata[base][31:0]);
        rows         = int'(p.num_rows);
        cols         = int'(p.num_cols);
        n_exp        = rows * ((cols + int'(p.kernel_len) - 1) / int'(p.kernel_len));
        pix_base     = base + 1 + int'(p.kernel_len);
        next         = pix_base + rows * cols + n_exp;
        fetch_start  = fetch_count;
        result_start = result_count;
        for (int i = 0; i < n_exp; i++) begin
            exp_q.push_back(tdata[pix_base + rows * cols + i]);
        end

        // Weight beats while idle
        for (int k = 0; k < int'(p.kernel_len); k++) begin
            tick();
            if (k > 0) begin
                check_bit("weight_ready", 1'b1, weight_ready);
            end
            weight_valid <= 1'b1;
            weight_data  <= tdata[base + 1 + k][63:0];
        end
        tick();
        check_bit("weight_ready", 1'b1, weight_ready);
        weight_valid   <= 1'b0;
        job_start      <= 1'b1;
        job_parameters <= p;
        tick();
        check_bit("job_accept_early", 1'b0, job_accept);
        job_start <= 1'b0;

        n = 0;
        tick();
        while (job_accept && n <= wait_limit) begin
            n++;
            tick();
        end
        check_count("job_accept_cycles", accept_stretch, n);

        // Weights are shut out once the job runs
        weight_valid <= 1'b1;
        tick();
        check_bit("weight_ready_busy", 1'b0, weight_ready);
        weight_valid <= 1'b0;

        for (int r = 0; r < rows; r++) begin
            n = 0;
            while (!job_fetch_request && n < wait_limit) begin
                tick();
                n++;
            end
            if (!job_fetch_request) begin
                fail_run("Timeout waiting for job_fetch_request");
            end
            job_fetch_ack <= 1'b1;
            tick();
            job_fetch_ack <= 1'b0;
            for (int c = 0; c < cols; c++) begin
                tick();
                if (c == 0) begin
                    check_bit("fetch_request_drop", 1'b0, job_fetch_request);
                end else begin
                    check_bit("pixel_ready", 1'b1, pixel_ready);
                end
                pixel_valid <= 1'b1;
                pixel_data  <= tdata[pix_base + r * cols + c][63:0];
            end
            tick();
            check_bit("pixel_ready", 1'b1, pixel_ready);
            pixel_valid        <= 1'b0;
            job_fetch_complete <= 1'b1;
            tick();
            job_fetch_complete <= 1'b0;
        end

        n = 0;
        while (!job_complete && n < wait_limit) begin
            tick();
            n++;
        end
        if (!job_complete) begin
            fail_run("Timeout waiting for job_complete");
        end
        job_complete_ack <= 1'b1;
        tick();
        job_complete_ack <= 1'b0;
        check_count("result_beats", n_exp, result_count - result_start);
        check_count("fetch_requests", rows, fetch_count - fetch_start);
        tick();
        check_bit("job_complete_drop", 1'b0, job_complete);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int ptr;
        int next;
        int job_idx;
        rst                = 1'b1;
        job_start          = 1'b0;
        job_parameters     = '0;
        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack   = 1'b0;
        weight_valid       = 1'b0;
        weight_data        = '0;
        pixel_valid        = 1'b0;
        pixel_data         = '0;
        $readmemh("test/quad_testdata.txt", tdata);
        if ($isunknown(tdata[0][31:0])) begin
            fail_run("Test data file is missing or empty");
        end

        repeat (8) tick();
        check_bit("job_accept", 1'b0, job_accept);
        check_bit("job_fetch_request", 1'b0, job_fetch_request);
        check_bit("job_complete", 1'b0, job_complete);
        check_bit("pixel_ready", 1'b0, pixel_ready);
        check_bit("weight_ready", 1'b0, weight_ready);
        check_bit("result_valid", 1'b0, result_valid);
        rst <= 1'b0;

        // No fetch open, so pixels must be refused
        tick();
        pixel_valid <= 1'b1;
        repeat (3) begin
            tick();
            check_bit("pixel_ready_idle", 1'b0, pixel_ready);
        end
        pixel_valid <= 1'b0;

        for (int pass = 0; pass < 2; pass++) begin
            stall_en <= (pass == 1);
            ptr     = 0;
            job_idx = 0;
            while (tdata[ptr][31:0] != '0) begin
                test_name = $sformatf("pass%0d_job%0d", pass, job_idx);
                run_job(ptr, next);
                ptr = next;
                job_idx++;
            end
            check_count("jobs_in_file", file_jobs, job_idx);
        end

        $display("Test OK");
        $finish;
    end

endmodule

// File: test/quad_testdata.txt
// Per job: params (rows cols kernel_len relu), kernel_len weight beats, rows*cols pixel beats,
// then expected window sums. Lane 3 is leftmost in every beat. A 0 word ends the list.
02040200
FFFE0001FFFD0002
FFFE00040001FFFF
00010005FFFC0003
0002FFFF0006FFFE
FFFD0002FFFB0007
0004FFFA0003FFFF
FFFF00030002FFF8
0005FFFEFFFD0004
FFFAFFFC00070001
00020006FFFFFFFB
FFFFFFFFFA000000000100000000120000000008
FFFFFFFFFEFFFFFFFFEA0000000012000000000F
FFFFFFFFF8FFFFFFFFFBFFFFFFFFF7FFFFFFFFEC
00000000080000000014FFFFFFFFEA0000000007
// Same weights and rows with ReLU on the pixels
02040280
FFFE0001FFFD0002
FFFE00040001FFFF
00010005FFFC0003
0002FFFF0006FFFE
FFFD0002FFFB0007
0004FFFA0003FFFF
FFFF00030002FFF8
0005FFFEFFFD0004
FFFAFFFC00070001
00020006FFFFFFFB
FFFFFFFFFA000000000500000000060000000006
FFFFFFFFF800000000020000000003000000000E
FFFFFFFFF60000000003FFFFFFFFFAFFFFFFFFFC
FFFFFFFFFC0000000018FFFFFFFFEB0000000002
0
